//--- compile.f
+incdir+testbench
rtl/video_pkg.sv
rtl/overlay_pkg.sv
rtl/pipe_delay.sv
rtl/test_pattern_gen.sv
rtl/box_config_regs.sv
rtl/box_hit.sv
rtl/box_priority_mix.sv
rtl/box_overlay_top.sv
testbench/tb_box_overlay.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of tb_box_overlay, output kept in sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_box_overlay \
    -f compile.f > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_box_overlay > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
exit 0

//--- testbench/tb_overlay_model.svh
`ifndef TB_OVERLAY_MODEL_SVH
`define TB_OVERLAY_MODEL_SVH

// pattern colour: red x*8, green y*8, blue fixed at 0x40
function automatic logic [23:0] pattern_color(input int px, input int py);
    logic [7:0] red;
    logic [7:0] grn;
    red = 8'((px * 8) % 256);
    grn = 8'((py * 8) % 256);
    return {red, grn, 8'h40};
endfunction

// pixel is on the outline of an enabled box
function automatic bit on_outline(
    input int px,
    input int py,
    input int sx,
    input int sy,
    input int ex,
    input int ey,
    input bit enabled,
    input int thick
);
    bit outer;
    bit inner;
    outer = (px >= sx) && (px <= ex) && (py >= sy) && (py <= ey);
    // strictly inside the inner rectangle
    inner = (px > sx + thick) && (px < ex - thick) &&
            (py > sy + thick) && (py < ey - thick);
    return enabled && outer && !inner;
endfunction

// 32 bit LCG step
function automatic int unsigned lcg_next(input int unsigned state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

`endif

//--- testbench/tb_box_overlay.sv
`timescale 1ns/1ps

module tb_box_overlay;

    localparam int H_ACT         = 32;
    localparam int V_ACT         = 24;
    localparam int H_TOTAL       = 40;
    localparam int V_TOTAL       = 28;
    localparam int H_SYNC        = 4;
    localparam int N_BOX         = 4;
    localparam int THICK         = 2;
    localparam int CW            = video_pkg::COORD_W;
    localparam int FRAMES_TESTED = 9;

    `include "tb_overlay_model.svh"

    logic                          clk;
    logic                          reset;
    logic                          en;
    logic                          cfg_wr;
    logic [overlay_pkg::IDX_W-1:0] cfg_index;
    overlay_pkg::box_field_e       cfg_field;
    logic [23:0]                   cfg_data;
    logic                          hsync;
    logic                          vsync;
    logic                          de;
    logic [CW-1:0]                 x;
    logic [CW-1:0]                 y;
    logic [7:0]                    r;
    logic [7:0]                    g;
    logic [7:0]                    b;
    logic [23:0]                   out_rgb;

    // copy of the box registers
    int          box_sx  [N_BOX];
    int          box_sy  [N_BOX];
    int          box_ex  [N_BOX];
    int          box_ey  [N_BOX];
    logic [23:0] box_col [N_BOX];
    bit          box_on  [N_BOX];

    logic [23:0] exp_rgb;
    logic        exp_de;
    logic        exp_hsync;
    logic        exp_vsync;
    int          exp_x;
    int          exp_y;
    int          prev_x;
    int          prev_y;
    logic [2:0]  rst_hist;  // reset seen at the last three edges
    logic [1:0]  run_cnt;
    logic        live;      // output carries real pixels
    logic        stepping;  // and did so one cycle earlier too
    int unsigned lcg_state;
    int          fail_count;
    int          fails_before;
    int          pixels_checked;
    int          tests_run;

    box_overlay_top #(
        .H_ACT  (H_ACT),
        .V_ACT  (V_ACT),
        .H_TOTAL(H_TOTAL),
        .V_TOTAL(V_TOTAL),
        .H_SYNC (H_SYNC),
        .N_BOX  (N_BOX),
        .THICK  (THICK)
    ) uut (
        .clk      (clk),
        .reset    (reset),
        .en       (en),
        .cfg_wr   (cfg_wr),
        .cfg_index(cfg_index),
        .cfg_field(cfg_field),
        .cfg_data (cfg_data),
        .hsync    (hsync),
        .vsync    (vsync),
        .de       (de),
        .x        (x),
        .y        (y),
        .r        (r),
        .g        (g),
        .b        (b)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    assign out_rgb   = {r, g, b};
    assign live      = (run_cnt >= 2'd2);
    assign stepping  = (run_cnt == 2'd3);
    assign exp_de    = (int'(x) < H_ACT) && (int'(y) < V_ACT);
    assign exp_hsync = (int'(x) >= H_ACT) && (int'(x) < H_ACT + H_SYNC);
    assign exp_vsync = (int'(y) == V_ACT);
    assign exp_x     = (prev_x + 1) % H_TOTAL;
    assign exp_y     = (prev_x == H_TOTAL - 1) ? (prev_y + 1) % V_TOTAL : prev_y;

    always_comb begin
        exp_rgb = pattern_color(int'(x), int'(y));
        if (en) begin
            for (int k = 0; k < N_BOX; k++) begin
                if (on_outline(int'(x), int'(y), box_sx[k], box_sy[k], box_ex[k], box_ey[k],
                               box_on[k], THICK)) begin
                    exp_rgb = box_col[k];  // later box wins
                end
            end
        end
    end

    always @(posedge clk) begin
        prev_x   <= int'(x);
        prev_y   <= int'(y);
        rst_hist <= {rst_hist[1:0], reset};
        if (reset) begin
            run_cnt <= 2'd0;
        end else if (run_cnt != 2'd3) begin
            run_cnt <= run_cnt + 2'd1;
        end
        if (live && de) begin
            pixels_checked <= pixels_checked + 1;
        end
    end

    a_reset_out: assert property (@(posedge clk)
        rst_hist[0] |-> !hsync && !vsync && !de && out_rgb == 24'h0
    ) else other_error("sync or colour output not cleared by reset");

    a_first_gap: assert property (@(posedge clk) rst_hist[1] && !rst_hist[0] |-> !de)
        else other_error("de already high one cycle after reset release");

    a_first_pixel: assert property (@(posedge clk)
        rst_hist[2] && !rst_hist[1] |-> de && x == '0 && y == '0
    ) else other_error("first pixel after reset is not de high at x 0, y 0");

    a_de: assert property (@(posedge clk) disable iff (reset) live |-> de == exp_de)
        else value_error("de", $sampled(exp_de), $sampled(de));

    a_hsync: assert property (@(posedge clk) disable iff (reset) live |-> hsync == exp_hsync)
        else value_error("hsync", $sampled(exp_hsync), $sampled(hsync));

    a_vsync: assert property (@(posedge clk) disable iff (reset) live |-> vsync == exp_vsync)
        else value_error("vsync", $sampled(exp_vsync), $sampled(vsync));

    a_x_step: assert property (@(posedge clk) disable iff (reset) stepping |-> int'(x) == exp_x)
        else value_error("x", $sampled(exp_x), $sampled(int'(x)));

    a_y_step: assert property (@(posedge clk) disable iff (reset) stepping |-> int'(y) == exp_y)
        else value_error("y", $sampled(exp_y), $sampled(int'(y)));

    a_color: assert property (@(posedge clk) disable iff (reset)
        live && de |-> out_rgb == exp_rgb
    ) else value_error("rgb", $sampled(exp_rgb), $sampled(out_rgb));

    task automatic value_error(input string name, input int expected, input int got);
        fail_count++;
        $display("Fail %0t %s expected 0x%0h got 0x%0h", $time, name, expected, got);
    endtask

    task automatic other_error(input string what);
        fail_count++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %0d %s: %0d failures", tests_run, name, fail_count - fails_before);
        fails_before = fail_count;
    endtask

    function automatic int unsigned draw_random();
        lcg_state = lcg_next(lcg_state);
        return lcg_state >> 8;
    endfunction

    // returns 1 ns after the edge that shows x 0 of the vsync line
    task automatic wait_blank();
        do begin
            @(posedge clk);
        end while (!(vsync && x == '0));
        #1;
    endtask

    task automatic cfg_write(input int k, input overlay_pkg::box_field_e field,
                             input logic [23:0] data);
        cfg_wr    = 1'b1;
        cfg_index = overlay_pkg::IDX_W'(k);
        cfg_field = field;
        cfg_data  = data;
        case (field)
            overlay_pkg::START_X: box_sx[k] = int'(data[CW-1:0]);
            overlay_pkg::START_Y: box_sy[k] = int'(data[CW-1:0]);
            overlay_pkg::END_X:   box_ex[k] = int'(data[CW-1:0]);
            overlay_pkg::END_Y:   box_ey[k] = int'(data[CW-1:0]);
            overlay_pkg::COLOR:   box_col[k] = data;
            overlay_pkg::ENABLE:  box_on[k] = data[0];
            default: ;
        endcase
        @(posedge clk);
        #1;
        cfg_wr = 1'b0;
    endtask

    // box off while its corners change
    task automatic set_box(input int k, input int sx, input int sy, input int ex, input int ey,
                           input logic [23:0] col, input bit on);
        cfg_write(k, overlay_pkg::ENABLE, 24'h0);
        cfg_write(k, overlay_pkg::START_X, 24'(sx));
        cfg_write(k, overlay_pkg::START_Y, 24'(sy));
        cfg_write(k, overlay_pkg::END_X, 24'(ex));
        cfg_write(k, overlay_pkg::END_Y, 24'(ey));
        cfg_write(k, overlay_pkg::COLOR, col);
        cfg_write(k, overlay_pkg::ENABLE, {23'h0, on});
    endtask

    // spans of at least 6 leave an inner rectangle on both axes
    task automatic random_box(input int k);
        int sx;
        int sy;
        int ex;
        int ey;
        sx = int'(draw_random() % 16);
        sy = int'(draw_random() % 12);
        ex = sx + 6 + int'(draw_random() % 32'(H_ACT - sx - 6));
        ey = sy + 6 + int'(draw_random() % 32'(V_ACT - sy - 6));
        set_box(k, sx, sy, ex, ey, 24'(draw_random()), 1'b1);
    endtask

    initial begin
        reset          = 1'b1;
        en             = 1'b0;
        cfg_wr         = 1'b0;
        cfg_index      = '0;
        cfg_field      = overlay_pkg::START_X;
        cfg_data       = '0;
        rst_hist       = '0;
        run_cnt        = '0;
        prev_x         = 0;
        prev_y         = 0;
        lcg_state      = 24145;
        fail_count     = 0;
        fails_before   = 0;
        pixels_checked = 0;
        tests_run      = 0;
        for (int k = 0; k < N_BOX; k++) begin
            box_sx[k]  = 0;
            box_sy[k]  = 0;
            box_ex[k]  = 0;
            box_ey[k]  = 0;
            box_col[k] = '0;
            box_on[k]  = 1'b0;
        end
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;

        do begin
            @(posedge clk);
        end while (!de);
        end_test("reset and first pixel");

        wait_blank();
        end_test("raster timing");

        en = 1'b1;  // nothing enabled yet
        wait_blank();
        set_box(0, 4, 4, 20, 16, 24'hff0000, 1'b1);
        en = 1'b0;
        wait_blank();
        end_test("pattern passthrough");

        en = 1'b1;
        wait_blank();
        random_box(0);
        wait_blank();
        end_test("single box");

        repeat (2) begin
            for (int k = 0; k < N_BOX; k++) begin
                random_box(k);
            end
            wait_blank();
        end
        en = draw_random() % 2 == 1;
        wait_blank();
        cfg_write(N_BOX - 1, overlay_pkg::ENABLE, 24'h0);
        en = 1'b1;
        wait_blank();
        end_test("overlapping boxes");

        $display("%0d tests, %0d active pixels checked, %0d failures",
                 tests_run, pixels_checked, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // twice the time of all tested frames
    initial begin
        #(FRAMES_TESTED * H_TOTAL * V_TOTAL * 20 * 2);
        $display("watchdog expired, the tests did not finish in time");
        $display("TB FAILED");
        $finish;
    end

endmodule : tb_box_overlay

//--- rtl/box_overlay_top.sv
`timescale 1ns/1ps

module box_overlay_top #(
    parameter int H_ACT   = 1280,
    parameter int V_ACT   = 720,
    parameter int H_TOTAL = 1650,
    parameter int V_TOTAL = 750,
    parameter int H_SYNC  = 40,
    parameter int N_BOX   = 4,
    parameter int THICK   = 2
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          en,
    input  logic                          cfg_wr,
    input  logic [overlay_pkg::IDX_W-1:0] cfg_index,
    input  overlay_pkg::box_field_e       cfg_field,
    input  logic [overlay_pkg::CFG_W-1:0] cfg_data,
    output logic                          hsync,
    output logic                          vsync,
    output logic                          de,
    output logic [video_pkg::COORD_W-1:0] x,
    output logic [video_pkg::COORD_W-1:0] y,
    output logic [7:0]                    r,
    output logic [7:0]                    g,
    output logic [7:0]                    b
);

    localparam int CW    = video_pkg::COORD_W;
    localparam int CFG_W = overlay_pkg::CFG_W;

    logic [CW-1:0]          gen_x;
    logic [CW-1:0]          gen_y;
    logic                   gen_hsync;
    logic                   gen_vsync;
    logic                   gen_de;
    video_pkg::rgb_t        pat_rgb;
    video_pkg::rgb_t        pat_rgb_d;
    video_pkg::rgb_t        mix_rgb;
    video_pkg::sync_t       sync_in;
    video_pkg::sync_t       sync_out;
    logic [2*CW-1:0]        xy_out;

    logic [N_BOX*CW-1:0]    start_xs;
    logic [N_BOX*CW-1:0]    start_ys;
    logic [N_BOX*CW-1:0]    end_xs;
    logic [N_BOX*CW-1:0]    end_ys;
    logic [N_BOX-1:0]       box_en;
    logic [N_BOX*CFG_W-1:0] colors;
    logic [N_BOX-1:0]       hit;

    test_pattern_gen #(
        .H_ACT  (H_ACT),
        .V_ACT  (V_ACT),
        .H_TOTAL(H_TOTAL),
        .V_TOTAL(V_TOTAL),
        .H_SYNC (H_SYNC)
    ) u_pattern (
        .clk    (clk),
        .reset  (reset),
        .x      (gen_x),
        .y      (gen_y),
        .hsync  (gen_hsync),
        .vsync  (gen_vsync),
        .de     (gen_de),
        .pat_rgb(pat_rgb)
    );

    box_config_regs #(
        .N_BOX(N_BOX)
    ) u_regs (
        .clk      (clk),
        .reset    (reset),
        .cfg_wr   (cfg_wr),
        .cfg_index(cfg_index),
        .cfg_field(cfg_field),
        .cfg_data (cfg_data),
        .start_xs (start_xs),
        .start_ys (start_ys),
        .end_xs   (end_xs),
        .end_ys   (end_ys),
        .box_en   (box_en),
        .colors   (colors)
    );

    for (genvar k = 0; k < N_BOX; k++) begin : g_hit
        box_hit #(
            .THICK(THICK)
        ) u_hit (
            .clk    (clk),
            .reset  (reset),
            .x      (gen_x),
            .y      (gen_y),
            .start_x(start_xs[k*CW +: CW]),
            .start_y(start_ys[k*CW +: CW]),
            .end_x  (end_xs[k*CW +: CW]),
            .end_y  (end_ys[k*CW +: CW]),
            .enable (box_en[k]),
            .hit    (hit[k])
        );
    end

    // pattern lines up with the registered hit bits
    pipe_delay #(
        .payload_t(video_pkg::rgb_t),
        .DEPTH    (1)
    ) u_pat_delay (
        .clk  (clk),
        .reset(reset),
        .din  (pat_rgb),
        .dout (pat_rgb_d)
    );

    box_priority_mix #(
        .N_BOX(N_BOX)
    ) u_mix (
        .clk    (clk),
        .reset  (reset),
        .en     (en),
        .hit    (hit),
        .colors (colors),
        .pat_rgb(pat_rgb_d),
        .rgb    (mix_rgb)
    );

    assign sync_in.hsync = gen_hsync;
    assign sync_in.vsync = gen_vsync;
    assign sync_in.de    = gen_de;

    // two stages, hit register plus mix register
    pipe_delay #(
        .payload_t(video_pkg::sync_t),
        .DEPTH    (2)
    ) u_sync_delay (
        .clk  (clk),
        .reset(reset),
        .din  (sync_in),
        .dout (sync_out)
    );

    pipe_delay #(
        .payload_t(logic [2*CW-1:0]),
        .DEPTH    (2)
    ) u_xy_delay (
        .clk  (clk),
        .reset(reset),
        .din  ({gen_x, gen_y}),
        .dout (xy_out)
    );

    assign hsync = sync_out.hsync;
    assign vsync = sync_out.vsync;
    assign de    = sync_out.de;
    assign x     = xy_out[2*CW-1:CW];
    assign y     = xy_out[CW-1:0];
    assign r     = mix_rgb.r;
    assign g     = mix_rgb.g;
    assign b     = mix_rgb.b;

endmodule : box_overlay_top

//--- rtl/box_priority_mix.sv
`timescale 1ns/1ps

module box_priority_mix #(
    parameter int N_BOX = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                en,
    input  logic [N_BOX-1:0]                    hit,
    input  logic [N_BOX*overlay_pkg::CFG_W-1:0] colors,
    input  video_pkg::rgb_t                     pat_rgb,
    output video_pkg::rgb_t                     rgb
);

    localparam int CFG_W = overlay_pkg::CFG_W;

    overlay_pkg::box_color_t top_color;
    logic                    any_hit;

    // later boxes overwrite earlier ones, highest index wins
    always_comb begin
        top_color = '0;
        any_hit   = 1'b0;
        for (int k = 0; k < N_BOX; k++) begin
            if (hit[k]) begin
                top_color = colors[k*CFG_W +: CFG_W];
                any_hit   = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rgb <= '0;
        end else if (en && any_hit) begin
            rgb <= top_color;
        end else begin
            rgb <= pat_rgb;  // pattern passes through
        end
    end

endmodule : box_priority_mix

//--- rtl/box_hit.sv
`timescale 1ns/1ps

module box_hit #(
    parameter int THICK = 2
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [video_pkg::COORD_W-1:0] x,
    input  logic [video_pkg::COORD_W-1:0] y,
    input  logic [video_pkg::COORD_W-1:0] start_x,
    input  logic [video_pkg::COORD_W-1:0] start_y,
    input  logic [video_pkg::COORD_W-1:0] end_x,
    input  logic [video_pkg::COORD_W-1:0] end_y,
    input  logic                          enable,
    output logic                          hit
);

    localparam int CW = video_pkg::COORD_W;
    localparam logic [CW:0] THICK_E = (CW + 1)'(THICK);

    logic in_outer;
    logic in_inner;

    assign in_outer = (x >= start_x) && (x <= end_x) && (y >= start_y) && (y <= end_y);

    // one extra bit so corner +- THICK cannot wrap
    assign in_inner = ({1'b0, x} > {1'b0, start_x} + THICK_E) &&
                      ({1'b0, x} + THICK_E < {1'b0, end_x}) &&
                      ({1'b0, y} > {1'b0, start_y} + THICK_E) &&
                      ({1'b0, y} + THICK_E < {1'b0, end_y});

    always_ff @(posedge clk) begin
        if (reset) begin
            hit <= 1'b0;
        end else begin
            hit <= enable && in_outer && !in_inner;
        end
    end

    // corners come from the register bank, must be ordered once enabled
    a_corner_order: assert property (@(posedge clk) disable iff (reset)
        enable |-> (start_x <= end_x) && (start_y <= end_y)
    ) else $error("enabled box has start beyond end");

endmodule : box_hit

//--- rtl/box_config_regs.sv
`timescale 1ns/1ps

module box_config_regs #(
    parameter int N_BOX = 4
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  cfg_wr,
    input  logic [overlay_pkg::IDX_W-1:0]         cfg_index,
    input  overlay_pkg::box_field_e               cfg_field,
    input  logic [overlay_pkg::CFG_W-1:0]         cfg_data,
    output logic [N_BOX*video_pkg::COORD_W-1:0]   start_xs,
    output logic [N_BOX*video_pkg::COORD_W-1:0]   start_ys,
    output logic [N_BOX*video_pkg::COORD_W-1:0]   end_xs,
    output logic [N_BOX*video_pkg::COORD_W-1:0]   end_ys,
    output logic [N_BOX-1:0]                      box_en,
    output logic [N_BOX*overlay_pkg::CFG_W-1:0]   colors
);

    localparam int CW    = video_pkg::COORD_W;
    localparam int CFG_W = overlay_pkg::CFG_W;

    logic [CW-1:0]           start_x_q [N_BOX];
    logic [CW-1:0]           start_y_q [N_BOX];
    logic [CW-1:0]           end_x_q   [N_BOX];
    logic [CW-1:0]           end_y_q   [N_BOX];
    overlay_pkg::box_color_t color_q   [N_BOX];
    logic [N_BOX-1:0]        sel;

    // one-hot box select, out of range index selects nothing
    always_comb begin
        for (int k = 0; k < N_BOX; k++) begin
            sel[k] = cfg_wr && (cfg_index == overlay_pkg::IDX_W'(k));
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < N_BOX; k++) begin
            if (sel[k]) begin
                case (cfg_field)
                    overlay_pkg::START_X: start_x_q[k] <= cfg_data[CW-1:0];
                    overlay_pkg::START_Y: start_y_q[k] <= cfg_data[CW-1:0];
                    overlay_pkg::END_X:   end_x_q[k]   <= cfg_data[CW-1:0];
                    overlay_pkg::END_Y:   end_y_q[k]   <= cfg_data[CW-1:0];
                    overlay_pkg::COLOR:   color_q[k]   <= cfg_data;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            box_en <= '0;
        end else begin
            for (int k = 0; k < N_BOX; k++) begin
                if (sel[k] && cfg_field == overlay_pkg::ENABLE) begin
                    box_en[k] <= cfg_data[0];
                end
            end
        end
    end

    for (genvar k = 0; k < N_BOX; k++) begin : g_flat
        assign start_xs[k*CW +: CW]     = start_x_q[k];
        assign start_ys[k*CW +: CW]     = start_y_q[k];
        assign end_xs[k*CW +: CW]       = end_x_q[k];
        assign end_ys[k*CW +: CW]       = end_y_q[k];
        assign colors[k*CFG_W +: CFG_W] = color_q[k];
    end

    a_index_range: assert property (@(posedge clk) disable iff (reset)
        cfg_wr |-> (cfg_index < N_BOX)
    ) else $error("config write to box %0d, only %0d boxes", cfg_index, N_BOX);

endmodule : box_config_regs

//--- rtl/test_pattern_gen.sv
`timescale 1ns/1ps

module test_pattern_gen #(
    parameter int H_ACT   = 1280,
    parameter int V_ACT   = 720,
    parameter int H_TOTAL = 1650,
    parameter int V_TOTAL = 750,
    parameter int H_SYNC  = 40
) (
    input  logic                          clk,
    input  logic                          reset,
    output logic [video_pkg::COORD_W-1:0] x,
    output logic [video_pkg::COORD_W-1:0] y,
    output logic                          hsync,
    output logic                          vsync,
    output logic                          de,
    output video_pkg::rgb_t               pat_rgb
);

    localparam int CW = video_pkg::COORD_W;

    logic x_wrap;
    logic y_wrap;

    assign x_wrap = (x == CW'(H_TOTAL - 1));
    assign y_wrap = (y == CW'(V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            x <= '0;
            y <= '0;
        end else begin
            x <= x_wrap ? '0 : x + 1'b1;
            if (x_wrap) begin
                y <= y_wrap ? '0 : y + 1'b1; // next line
            end
        end
    end

    // decode straight from the counters so sync stays aligned with x, y
    assign de    = (x < CW'(H_ACT)) && (y < CW'(V_ACT));
    assign hsync = (x >= CW'(H_ACT)) && (x < CW'(H_ACT + H_SYNC));
    assign vsync = (y == CW'(V_ACT));  // first blank line only

    // x*8 and y*8, low byte
    assign pat_rgb.r = {x[4:0], 3'b000};
    assign pat_rgb.g = {y[4:0], 3'b000};
    assign pat_rgb.b = video_pkg::PAT_BLUE;

    a_x_range: assert property (@(posedge clk) disable iff (reset)
        x < CW'(H_TOTAL)
    ) else $error("x counter ran past H_TOTAL");

endmodule : test_pattern_gen

//--- rtl/pipe_delay.sv
`timescale 1ns/1ps

module pipe_delay #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     reset,
    input  payload_t din,
    output payload_t dout
);

    payload_t stage [DEPTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[DEPTH-1];

endmodule : pipe_delay

//--- rtl/overlay_pkg.sv
package overlay_pkg;

    // box number on the config port, room for up to 16 boxes
    localparam int IDX_W = 4;

    // box colours share the raster pixel layout
    typedef video_pkg::rgb_t box_color_t;

    localparam int CFG_W = $bits(box_color_t);

    // field select of a config write
    typedef enum logic [2:0] {
        START_X = 3'd0,
        START_Y = 3'd1,
        END_X   = 3'd2,
        END_Y   = 3'd3,
        COLOR   = 3'd4,
        ENABLE  = 3'd5
    } box_field_e;

endpackage : overlay_pkg

//--- rtl/video_pkg.sv
package video_pkg;

    // raster coordinates, wide enough for 1080p totals
    localparam int COORD_W = 12;

    localparam int CHAN_W = 8;

    // fixed blue level of the test pattern
    localparam logic [CHAN_W-1:0] PAT_BLUE = 8'h40;

    typedef struct packed {
        logic [CHAN_W-1:0] r;
        logic [CHAN_W-1:0] g;
        logic [CHAN_W-1:0] b;
    } rgb_t;

    // sync bundle carried alongside the pixel
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } sync_t;

endpackage : video_pkg
